// ==== ahbl_pkg.sv ====
// AHB-Lite protocol definitions
// Transfer types, codes and the request and response structs shared by
// every module that sits on the bus
package ahbl_pkg;

    typedef logic [31:0] haddr_t;
    typedef logic [31:0] hdata_t;
    typedef logic [1:0]  htrans_t;
    typedef logic [2:0]  hsize_t;

    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;

    // Address phase as driven by the master
    typedef struct packed {
        haddr_t  haddr;
        logic    hwrite;
        htrans_t htrans;
        hsize_t  hsize;
    } ahbl_req_t;

    // Decoder to slave, address phase plus write data
    typedef struct packed {
        logic    hsel;
        logic    hready;     // Bus hready, formed by the decoder
        haddr_t  haddr;
        logic    hwrite;
        htrans_t htrans;
        hsize_t  hsize;
        hdata_t  hwdata;
    } ahbl_slv_req_t;

    typedef struct packed {
        logic   hready_resp;
        logic   hresp;
        hdata_t hrdata;
    } ahbl_rsp_t;

endpackage

// ==== sys_pkg.sv ====
// Subsystem definitions
// Address map defaults, the SRAM macro port and the offsets of the
// system control registers
package sys_pkg;

    // Top address byte selects the region
    typedef logic [7:0] region_t;

    localparam region_t SRAM_BASE_DEF = 8'h20;
    localparam region_t REGS_BASE_DEF = 8'h27;

    // 2048 words of 32 bits
    localparam int SRAM_AW = 11;

    typedef logic [SRAM_AW-1:0] sram_addr_t;

    // Inputs of the single-port macro
    typedef struct packed {
        logic        en;     // Chip select, active high
        logic        r_wb;   // 1 read, 0 write
        sram_addr_t  addr;
        logic [31:0] wdata;
        logic [31:0] ben;    // Bit enables, active high
    } sram_port_t;

    // Register offsets within the register region
    localparam logic [7:0] REG_VREF   = 8'h00;
    localparam logic [7:0] REG_IRQ_EN = 8'h04;
    localparam logic [7:0] REG_CFG    = 8'h08;
    localparam logic [7:0] REG_STATUS = 8'h0C;

endpackage

// ==== ahbl_decoder.sv ====
// AHB-Lite address decoder
// Routes each transfer by its top address byte to the SRAM or the
// register block, returns the owning slave's response and answers
// unmapped addresses with the two-cycle error response
`timescale 1ns/1ps

module ahbl_decoder #(
    parameter sys_pkg::region_t SRAM_BASE = sys_pkg::SRAM_BASE_DEF,
    parameter sys_pkg::region_t REGS_BASE = sys_pkg::REGS_BASE_DEF
) (
    input  logic                    clk,
    input  logic                    rst,
    input  ahbl_pkg::ahbl_req_t     req,
    input  ahbl_pkg::hdata_t        hwdata,
    output ahbl_pkg::ahbl_rsp_t     rsp,
    output ahbl_pkg::ahbl_slv_req_t sram_req,
    input  ahbl_pkg::ahbl_rsp_t     sram_rsp,
    output ahbl_pkg::ahbl_slv_req_t regs_req,
    input  ahbl_pkg::ahbl_rsp_t     regs_rsp
);
    import ahbl_pkg::*;
    import sys_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_ERR1, ST_ERR2} err_state_t;

    err_state_t state;
    err_state_t state_d;
    region_t    region;
    logic       hit_sram;
    logic       hit_regs;
    logic       hready;
    logic       accept;
    logic       dp_sram;   // SRAM owns the data phase
    logic       dp_regs;   // Registers own the data phase

    assign region   = req.haddr[31:24];
    assign hit_sram = (region == SRAM_BASE);
    assign hit_regs = (region == REGS_BASE);
    assign hready   = rsp.hready_resp;
    assign accept   = hready && (req.htrans == HTRANS_NONSEQ);

    // Same address phase to both slaves, only hsel differs
    always_comb begin
        sram_req = '{hsel: hit_sram, hready: hready, haddr: req.haddr, hwrite: req.hwrite,
                     htrans: req.htrans, hsize: req.hsize, hwdata: hwdata};
        regs_req      = sram_req;
        regs_req.hsel = hit_regs;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dp_sram <= 1'b0;
            dp_regs <= 1'b0;
        end else if (hready) begin
            dp_sram <= accept && hit_sram;
            dp_regs <= accept && hit_regs;
        end
    end

    // Error response for addresses outside both regions
    always_comb begin
        state_d = ST_IDLE;
        if (state == ST_ERR1) begin
            state_d = ST_ERR2;
        end else if (accept && !hit_sram && !hit_regs) begin
            state_d = ST_ERR1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_d;
        end
    end

    always_comb begin
        rsp = '{hready_resp: 1'b1, hresp: 1'b0, hrdata: '0};  // Idle bus
        if (dp_sram) begin
            rsp = sram_rsp;
        end else if (dp_regs) begin
            rsp = regs_rsp;
        end else if (state == ST_ERR1) begin
            rsp.hready_resp = 1'b0;
            rsp.hresp       = 1'b1;
        end else if (state == ST_ERR2) begin
            rsp.hresp = 1'b1;
        end
    end

    // At most one owner of the data phase, a slave or the error response
    a_one_owner: assert property (@(posedge clk) disable iff (rst)
        $onehot0({dp_sram, dp_regs, state != ST_IDLE}));

endmodule

// ==== sram_ahbl_ctrl.sv ====
// AHB-Lite controller for a synchronous single-port SRAM macro
// Reads go to the macro in the address phase, writes in the data phase
// with bit enables from the byte lanes. A read that meets a pending
// write is held for one cycle
`timescale 1ns/1ps

module sram_ahbl_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  ahbl_pkg::ahbl_slv_req_t bus,
    output ahbl_pkg::ahbl_rsp_t     rsp,
    output sys_pkg::sram_port_t     sram,
    input  ahbl_pkg::hdata_t        sram_rdata
);
    import ahbl_pkg::*;
    import sys_pkg::*;

    logic       accept;
    logic       wr_pend;   // Write data phase, macro write this cycle
    logic       rd_defer;  // Read held behind a write, issued now
    logic       rd_issue;
    sram_addr_t addr_q;
    hsize_t     size_q;
    logic [1:0] lane_q;
    logic [3:0] byte_en;

    // Byte lanes touched by a transfer of the given size and alignment
    function automatic logic [3:0] lane_mask(input hsize_t size, input logic [1:0] lane);
        logic [3:0] mask;
        case (size)
            3'd0:    mask = 4'b0001 << lane;
            3'd1:    mask = lane[1] ? 4'b1100 : 4'b0011;
            default: mask = 4'b1111;
        endcase
        return mask;
    endfunction

    assign accept   = bus.hsel && bus.hready && (bus.htrans == HTRANS_NONSEQ);
    assign rd_issue = rd_defer || (accept && !bus.hwrite && !wr_pend);
    assign byte_en  = lane_mask(size_q, lane_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_pend  <= 1'b0;
            rd_defer <= 1'b0;
        end else begin
            if (bus.hready) begin
                wr_pend <= accept && bus.hwrite;
            end
            rd_defer <= accept && !bus.hwrite && wr_pend;  // Port busy with the write
        end
    end

    // Address phase kept for the write and for a held read
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= bus.haddr[SRAM_AW+1:2];
            size_q <= bus.hsize;
            lane_q <= bus.haddr[1:0];
        end
    end

    always_comb begin
        sram.en    = wr_pend || rd_issue;
        sram.r_wb  = !wr_pend;
        sram.addr  = (wr_pend || rd_defer) ? addr_q : bus.haddr[SRAM_AW+1:2];
        sram.wdata = bus.hwdata;  // Master already places bytes on their lanes
        sram.ben   = {{8{byte_en[3]}}, {8{byte_en[2]}}, {8{byte_en[1]}}, {8{byte_en[0]}}};
    end

    // Macro output is registered, so it lines up with the data phase
    assign rsp = '{hready_resp: !rd_defer, hresp: 1'b0, hrdata: sram_rdata};

    a_no_rw_clash: assert property (@(posedge clk) disable iff (rst)
        !(wr_pend && rd_issue));

endmodule

// ==== sys_ctrl_regs.sv ====
// System control registers on AHB-Lite
// Holds the vref controls, the user interrupt enables and the serial
// config, all readable back, plus a status word with mgmt_select
`timescale 1ns/1ps

module sys_ctrl_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  ahbl_pkg::ahbl_slv_req_t bus,
    output ahbl_pkg::ahbl_rsp_t     rsp,
    output logic                    vref_e_vrefgen_en,
    output logic                    vref_w_vrefgen_en,
    output logic [4:0]              vref_e_ref_sel,
    output logic [4:0]              vref_w_ref_sel,
    output logic [15:0]             user_irqs_enable,
    output logic                    user_ahb_enable,
    output logic [5:0]              sio_cfg,
    input  logic                    mgmt_select
);
    import ahbl_pkg::*;
    import sys_pkg::*;

    logic        accept;
    logic        wr_q;      // Data phase is a write
    logic [7:0]  off_q;
    logic [11:0] vref_q;
    logic [15:0] irq_en_q;
    logic [6:0]  cfg_q;
    hdata_t      rdata;

    assign accept = bus.hsel && bus.hready && (bus.htrans == HTRANS_NONSEQ);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_q <= 1'b0;
        end else if (bus.hready) begin
            wr_q <= accept && bus.hwrite;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            off_q <= bus.haddr[7:0];
        end
    end

    // Write data arrives in the data phase
    always_ff @(posedge clk) begin
        if (rst) begin
            vref_q   <= '0;
            irq_en_q <= '0;
            cfg_q    <= '0;
        end else if (wr_q) begin
            case (off_q)
                REG_VREF:   vref_q   <= bus.hwdata[11:0];
                REG_IRQ_EN: irq_en_q <= bus.hwdata[15:0];
                REG_CFG:    cfg_q    <= bus.hwdata[6:0];
                default:    ;  // Status is read only
            endcase
        end
    end

    assign vref_e_vrefgen_en = vref_q[0];
    assign vref_w_vrefgen_en = vref_q[1];
    assign vref_e_ref_sel    = vref_q[6:2];
    assign vref_w_ref_sel    = vref_q[11:7];
    assign user_irqs_enable  = irq_en_q;
    assign user_ahb_enable   = cfg_q[0];
    assign sio_cfg           = cfg_q[6:1];

    always_comb begin
        rdata = '0;  // Unknown offsets read zero
        case (off_q)
            REG_VREF:   rdata = {20'd0, vref_q};
            REG_IRQ_EN: rdata = {16'd0, irq_en_q};
            REG_CFG:    rdata = {25'd0, cfg_q};
            REG_STATUS: rdata = {31'd0, mgmt_select};
            default:    rdata = '0;
        endcase
    end

    assign rsp = '{hready_resp: 1'b1, hresp: 1'b0, hrdata: rdata};

    // Every accepted transfer ends next cycle without error
    a_no_error: assert property (@(posedge clk) disable iff (rst)
        accept |=> (rsp.hready_resp && !rsp.hresp));

endmodule

// ==== ahbl_subsys.sv ====
// AHB-Lite subsystem top level
// One master port, an address decoder, the SRAM controller for the
// external macro and the system control registers
`timescale 1ns/1ps

module ahbl_subsys #(
    parameter sys_pkg::region_t SRAM_BASE = sys_pkg::SRAM_BASE_DEF,
    parameter sys_pkg::region_t REGS_BASE = sys_pkg::REGS_BASE_DEF
) (
    input  logic                clk,
    input  logic                rst,
    input  ahbl_pkg::ahbl_req_t req,
    input  ahbl_pkg::hdata_t    hwdata,
    output ahbl_pkg::ahbl_rsp_t rsp,
    output sys_pkg::sram_port_t sram_o,
    input  ahbl_pkg::hdata_t    sram_rdata,
    output logic                vref_e_vrefgen_en,
    output logic                vref_w_vrefgen_en,
    output logic [4:0]          vref_e_ref_sel,
    output logic [4:0]          vref_w_ref_sel,
    output logic [15:0]         user_irqs_enable,
    output logic                user_ahb_enable,
    output logic [5:0]          sio_cfg,
    input  logic                mgmt_select
);
    import ahbl_pkg::*;

    ahbl_slv_req_t sram_req;
    ahbl_slv_req_t regs_req;
    ahbl_rsp_t     sram_rsp;
    ahbl_rsp_t     regs_rsp;

    ahbl_decoder #(
        .SRAM_BASE (SRAM_BASE),
        .REGS_BASE (REGS_BASE)
    ) decoder_u (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .hwdata   (hwdata),
        .rsp      (rsp),
        .sram_req (sram_req),
        .sram_rsp (sram_rsp),
        .regs_req (regs_req),
        .regs_rsp (regs_rsp)
    );

    sram_ahbl_ctrl sram_ctrl_u (
        .clk        (clk),
        .rst        (rst),
        .bus        (sram_req),
        .rsp        (sram_rsp),
        .sram       (sram_o),
        .sram_rdata (sram_rdata)
    );

    sys_ctrl_regs sys_regs_u (
        .clk               (clk),
        .rst               (rst),
        .bus               (regs_req),
        .rsp               (regs_rsp),
        .vref_e_vrefgen_en (vref_e_vrefgen_en),
        .vref_w_vrefgen_en (vref_w_vrefgen_en),
        .vref_e_ref_sel    (vref_e_ref_sel),
        .vref_w_ref_sel    (vref_w_ref_sel),
        .user_irqs_enable  (user_irqs_enable),
        .user_ahb_enable   (user_ahb_enable),
        .sio_cfg           (sio_cfg),
        .mgmt_select       (mgmt_select)
    );

endmodule

// ==== ahbl_subsys_tb.sv ====
// Testbench for the AHB-Lite subsystem
// Runs a stimulus table through a pipelined AHB driver, with an SRAM macro
// model and shadow copies of memory and registers for the expected values
`timescale 1ns/1ps

module ahbl_subsys_tb;
    import ahbl_pkg::*;
    import sys_pkg::*;

    localparam int TIMEOUT = 20;
    localparam ahbl_req_t REQ_IDLE = '{haddr: '0, hwrite: 1'b0, htrans: HTRANS_IDLE,
                                       hsize: 3'd2};

    typedef struct packed {
        logic   wr;
        haddr_t addr;
        hsize_t size;
        hdata_t wdata;
        hdata_t rdata;   // Expected read data
        logic   hresp;   // Expected hresp
    } xfer_t;

    logic        clk = 1'b0;
    logic        rst;
    ahbl_req_t   req;
    hdata_t      hwdata;
    ahbl_rsp_t   rsp;
    sram_port_t  sram_o;
    hdata_t      sram_rdata;
    logic        vref_e_vrefgen_en;
    logic        vref_w_vrefgen_en;
    logic [4:0]  vref_e_ref_sel;
    logic [4:0]  vref_w_ref_sel;
    logic [15:0] user_irqs_enable;
    logic        user_ahb_enable;
    logic [5:0]  sio_cfg;
    logic        mgmt_select;

    hdata_t      mem [2**SRAM_AW];     // Macro contents
    hdata_t      shadow [2**SRAM_AW];  // Expected contents
    logic [31:0] lfsr = 32'h53d;
    logic [11:0] vref_exp;
    logic [15:0] irq_exp;
    logic [6:0]  cfg_exp;
    xfer_t       table_q[$];
    string       names[$];
    haddr_t      word_addr [4] = '{32'h2000_0010, 32'h2000_1ffc, 32'h2000_0400, 32'h2000_0004};
    hdata_t      w;

    always #2 clk = ~clk;

    ahbl_subsys ahbl_subsys_i (.*);

    // Single-port macro with a registered read port
    always @(posedge clk) begin
        if (sram_o.en) begin
            if (sram_o.r_wb) begin
                sram_rdata <= mem[sram_o.addr];
            end else begin
                mem[sram_o.addr] = (mem[sram_o.addr] & ~sram_o.ben) | (sram_o.wdata & sram_o.ben);
            end
        end
    end

    function automatic hdata_t fill_word(input int i);
        return i * 32'h0001_0003 ^ 32'h5a5a_a5a5;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_word(output hdata_t word);
        word = '0;
        for (int b = 0; b < 32; b++) begin
            word = {word[30:0], lfsr[0]};  // One step per bit
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "wrong value in %s", name);
        end
    endtask

    // A transfer of 2**size bytes covers the aligned lanes around the address
    task automatic shadow_write(input haddr_t addr, input hsize_t size, input hdata_t data);
        int         nbytes;
        int         first;
        sram_addr_t idx;
        nbytes = 1 << size;
        first  = int'(addr[1:0]) & ~(nbytes - 1);
        idx    = addr[SRAM_AW+1:2];
        for (int b = first; b < first + nbytes; b++) begin
            shadow[idx][8*b +: 8] = data[8*b +: 8];
        end
    endtask

    function automatic hdata_t reg_read(input logic [7:0] off);
        case (off)
            REG_VREF:   return {20'd0, vref_exp};
            REG_IRQ_EN: return {16'd0, irq_exp};
            REG_CFG:    return {25'd0, cfg_exp};
            REG_STATUS: return {31'd0, mgmt_select};
            default:    return '0;
        endcase
    endfunction

    task automatic add_xfer(input string name, input logic wr, input haddr_t addr,
                            input hsize_t size, input hdata_t wdata);
        xfer_t x;
        x = '{wr: wr, addr: addr, size: size, wdata: wdata, rdata: '0, hresp: 1'b0};
        if (addr[31:24] == SRAM_BASE_DEF) begin
            if (wr) begin
                shadow_write(addr, size, wdata);
            end else begin
                x.rdata = shadow[addr[SRAM_AW+1:2]];
            end
        end else if (addr[31:24] == REGS_BASE_DEF) begin
            if (wr && addr[7:0] == REG_VREF) vref_exp = wdata[11:0];
            if (wr && addr[7:0] == REG_IRQ_EN) irq_exp = wdata[15:0];
            if (wr && addr[7:0] == REG_CFG) cfg_exp = wdata[6:0];
            if (!wr) x.rdata = reg_read(addr[7:0]);
        end else begin
            x.hresp = 1'b1;  // Unmapped region
        end
        table_q.push_back(x);
        names.push_back(name);
    endtask

    task automatic wait_hready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!rsp.hready_resp) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timeout: hready_resp stayed low for %0d cycles", cycles);
                $display("*** FAILED ***");
                $fatal(1, "bus stalled");
            end
            @(negedge clk);
        end
    endtask

    // Address phase of entry i overlaps the data phase of entry i-1
    task automatic run_table();
        int prev;
        prev = -1;
        for (int i = 0; i <= table_q.size(); i++) begin
            @(posedge clk);
            if (i < table_q.size()) begin
                req <= '{haddr: table_q[i].addr, hwrite: table_q[i].wr,
                         htrans: HTRANS_NONSEQ, hsize: table_q[i].size};
            end else begin
                req <= REQ_IDLE;
            end
            if (prev >= 0) hwdata <= table_q[prev].wdata;
            wait_hready();  // Held address phase stays on the bus meanwhile
            if (prev >= 0) begin
                check_value({names[prev], " hresp"}, 32'(table_q[prev].hresp), 32'(rsp.hresp));
                // Read data carries no meaning on an error response
                if (!table_q[prev].wr && !table_q[prev].hresp) begin
                    check_value(names[prev], table_q[prev].rdata, rsp.hrdata);
                end
            end
            prev = i;
        end
    endtask

    initial begin
        rst         <= 1'b1;
        req         <= REQ_IDLE;
        hwdata      <= '0;
        sram_rdata  <= '0;
        mgmt_select <= 1'b1;
        vref_exp = '0;
        irq_exp  = '0;
        cfg_exp  = '0;
        for (int i = 0; i < 2**SRAM_AW; i++) begin
            mem[i]    = fill_word(i);
            shadow[i] = fill_word(i);
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("reset hready", 32'd1, 32'(rsp.hready_resp));
        check_value("reset hresp and en", 32'd0, 32'({rsp.hresp, sram_o.en}));
        check_value("reset vref", 32'd0, 32'({vref_e_vrefgen_en, vref_w_vrefgen_en,
                                              vref_e_ref_sel, vref_w_ref_sel}));
        check_value("reset irq and cfg", 32'd0, 32'({user_irqs_enable, user_ahb_enable, sio_cfg}));

        for (int k = 0; k < 4; k++) begin
            take_word(w);
            add_xfer($sformatf("sram word write %0d", k), 1'b1, word_addr[k], 3'd2, w);
        end
        for (int k = 0; k < 4; k++) begin
            add_xfer($sformatf("sram word read %0d", k), 1'b0, word_addr[k], 3'd2, '0);
        end
        // Lane merging within one word
        take_word(w);
        add_xfer("merge word", 1'b1, 32'h2000_0020, 3'd2, w);
        take_word(w);
        add_xfer("merge byte 1", 1'b1, 32'h2000_0021, 3'd0, w);
        take_word(w);
        add_xfer("merge half 2", 1'b1, 32'h2000_0022, 3'd1, w);
        take_word(w);
        add_xfer("merge byte 0", 1'b1, 32'h2000_0020, 3'd0, w);
        add_xfer("merge read", 1'b0, 32'h2000_0020, 3'd2, '0);
        take_word(w);
        add_xfer("b2b write", 1'b1, 32'h2000_0030, 3'd2, w);
        add_xfer("b2b read", 1'b0, 32'h2000_0030, 3'd2, '0);

        add_xfer("vref after reset", 1'b0, 32'h2700_0000 + REG_VREF, 3'd2, '0);
        take_word(w);
        add_xfer("vref write", 1'b1, 32'h2700_0000 + REG_VREF, 3'd2, w);
        add_xfer("vref read", 1'b0, 32'h2700_0000 + REG_VREF, 3'd2, '0);
        take_word(w);
        add_xfer("irq write", 1'b1, 32'h2700_0000 + REG_IRQ_EN, 3'd2, w);
        add_xfer("irq read", 1'b0, 32'h2700_0000 + REG_IRQ_EN, 3'd2, '0);
        take_word(w);
        add_xfer("cfg write", 1'b1, 32'h2700_0000 + REG_CFG, 3'd2, w);
        add_xfer("cfg read", 1'b0, 32'h2700_0000 + REG_CFG, 3'd2, '0);
        add_xfer("status read", 1'b0, 32'h2700_0000 + REG_STATUS, 3'd2, '0);
        add_xfer("unknown reg read", 1'b0, 32'h2700_0010, 3'd2, '0);

        add_xfer("unmapped read", 1'b0, 32'h2300_0000, 3'd2, '0);
        add_xfer("unmapped write", 1'b1, 32'h2300_0000, 3'd2, 32'h1234_5678);
        add_xfer("read after error", 1'b0, word_addr[0], 3'd2, '0);

        run_table();
        @(negedge clk);
        check_value("vref outputs", 32'(vref_exp), 32'({vref_w_ref_sel, vref_e_ref_sel,
                                                        vref_w_vrefgen_en, vref_e_vrefgen_en}));
        check_value("irq outputs", 32'(irq_exp), 32'(user_irqs_enable));
        check_value("cfg outputs", 32'(cfg_exp), 32'({sio_cfg, user_ahb_enable}));
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== list.f ====
ahbl_pkg.sv
sys_pkg.sv
ahbl_decoder.sv
sram_ahbl_ctrl.sv
sys_ctrl_regs.sv
ahbl_subsys.sv
ahbl_subsys_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the AHB-Lite subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module ahbl_subsys_tb \
    --Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0
